// ==== common/vdp_cmd_pkg.sv ====
package vdp_cmd_pkg;

  // Datapath widths
  localparam int VRAM_ADDR_W = 17;
  localparam int COORD_X_W   = 9;
  localparam int COORD_Y_W   = 10;
  // Working X keeps room for the border carry
  localparam int X_TMP_W     = 11;
  localparam int DATA_W      = 8;

  // Command opcodes, upper nibble of R46
  localparam logic [3:0] OP_STOP  = 4'b0000;
  localparam logic [3:0] OP_POINT = 4'b0100;
  localparam logic [3:0] OP_PSET  = 4'b0101;
  localparam logic [3:0] OP_SRCH  = 4'b0110;
  localparam logic [3:0] OP_LMMV  = 4'b1000;
  localparam logic [3:0] OP_HMMV  = 4'b1100;

  // Logical operations, R46 bits 2..0
  // Bit 3 selects the transparent variant
  localparam logic [2:0] LOP_IMP = 3'b000;
  localparam logic [2:0] LOP_AND = 3'b001;
  localparam logic [2:0] LOP_OR  = 3'b010;
  localparam logic [2:0] LOP_EOR = 3'b011;
  localparam logic [2:0] LOP_NOT = 3'b100;

  // Register index, register number minus 32
  localparam logic [3:0] REG_SX_L = 4'd0;
  localparam logic [3:0] REG_SX_H = 4'd1;
  localparam logic [3:0] REG_SY_L = 4'd2;
  localparam logic [3:0] REG_SY_H = 4'd3;
  localparam logic [3:0] REG_DX_L = 4'd4;
  localparam logic [3:0] REG_DX_H = 4'd5;
  localparam logic [3:0] REG_DY_L = 4'd6;
  localparam logic [3:0] REG_DY_H = 4'd7;
  localparam logic [3:0] REG_NX_L = 4'd8;
  localparam logic [3:0] REG_NX_H = 4'd9;
  localparam logic [3:0] REG_NY_L = 4'd10;
  localparam logic [3:0] REG_NY_H = 4'd11;
  localparam logic [3:0] REG_CLR  = 4'd12;
  localparam logic [3:0] REG_ARG  = 4'd13;
  localparam logic [3:0] REG_CMD  = 4'd14;

  // Active bitmap mode
  typedef enum logic [1:0] {
    MODE_G4,
    MODE_G5,
    MODE_G6,
    MODE_G7
  } screen_mode_t;

  // Command FSM states
  typedef enum logic [3:0] {
    ST_IDLE,
    ST_CHK_LOOP,
    ST_RD,
    ST_WAIT_RD,
    ST_PRE_RD,
    ST_WAIT_PRE_RD,
    ST_WR,
    ST_WAIT_WR,
    ST_SRCH_CHK,
    ST_END
  } cmd_state_t;

endpackage

// ==== common/cmd_regs_if.sv ====
interface cmd_regs_if import vdp_cmd_pkg::*; ();

  // R32..R43 coordinates and sizes
  logic [COORD_X_W-1:0] sx;
  logic [COORD_Y_W-1:0] sy;
  logic [COORD_X_W-1:0] dx;
  logic [COORD_Y_W-1:0] dy;
  logic [COORD_Y_W-1:0] nx;
  logic [COORD_Y_W-1:0] ny;
  // R44 colour
  logic [DATA_W-1:0]    clr;
  // R45 argument bits
  logic                 eq;
  logic                 dix;
  logic                 diy;
  // R46 opcode and logic op
  logic [DATA_W-1:0]    cmr;

  modport bank (output sx, sy, dx, dy, nx, ny, clr, eq, dix, diy, cmr);
  modport user (input sx, sy, dx, dy, nx, ny, clr, eq, dix, diy, cmr);

endinterface

// ==== logic/cmd_reg_bank.sv ====
module cmd_reg_bank import vdp_cmd_pkg::*; (
  input  logic              RESET,
  input  logic              CLK21M,
  input  logic              reg_wr_req,
  input  logic [3:0]        reg_num,
  input  logic [DATA_W-1:0] reg_data,
  input  logic              mode_valid,
  input  logic              start_take,
  input  logic              load_point,
  input  logic [DATA_W-1:0] point_data,
  input  logic [DATA_W-1:0] col_mask,
  input  logic              ce,
  output logic              reg_wr_ack,
  output logic              start_pend,
  cmd_regs_if.bank          regs
);

  always_ff @(posedge RESET or posedge CLK21M) begin
    if (CLK21M) begin
      reg_wr_ack <= 1'b0;
      start_pend <= 1'b0;
      regs.sx    <= '0;
      regs.sy    <= '0;
      regs.dx    <= '0;
      regs.dy    <= '0;
      regs.nx    <= '0;
      regs.ny    <= '0;
      regs.clr   <= '0;
      regs.eq    <= 1'b0;
      regs.dix   <= 1'b0;
      regs.diy   <= 1'b0;
      regs.cmr   <= '0;
    end else if (reg_wr_req != reg_wr_ack) begin
      // Pending write, acknowledge by toggling
      reg_wr_ack <= ~reg_wr_ack;
      case (reg_num)
        REG_SX_L: regs.sx[7:0] <= reg_data;
        REG_SX_H: regs.sx[8]   <= reg_data[0];
        REG_SY_L: regs.sy[7:0] <= reg_data;
        REG_SY_H: regs.sy[9:8] <= reg_data[1:0];
        REG_DX_L: regs.dx[7:0] <= reg_data;
        REG_DX_H: regs.dx[8]   <= reg_data[0];
        REG_DY_L: regs.dy[7:0] <= reg_data;
        REG_DY_H: regs.dy[9:8] <= reg_data[1:0];
        REG_NX_L: regs.nx[7:0] <= reg_data;
        REG_NX_H: regs.nx[9:8] <= reg_data[1:0];
        REG_NY_L: regs.ny[7:0] <= reg_data;
        REG_NY_H: regs.ny[9:8] <= reg_data[1:0];
        // Colour trimmed to the dot width while running
        REG_CLR:  regs.clr <= ce ? (reg_data & col_mask) : reg_data;
        REG_ARG: begin
          regs.eq  <= reg_data[1];
          regs.dix <= reg_data[2];
          regs.diy <= reg_data[3];
        end
        REG_CMD: begin
          regs.cmr   <= reg_data;
          // No start outside the bitmap modes
          start_pend <= mode_valid;
        end
        default: begin
        end
      endcase
    end else begin
      if (start_take) begin
        start_pend <= 1'b0;
      end
      // POINT result lands in the colour register
      if (load_point) begin
        regs.clr <= point_data;
      end
    end
  end

endmodule

// ==== logic/area_counter.sv ====
module area_counter import vdp_cmd_pkg::*; (
  input  logic                 RESET,
  input  logic                 CLK21M,
  input  screen_mode_t         mode,
  input  logic                 init,
  input  logic                 step_x,
  input  logic                 next_line,
  cmd_regs_if.user             regs,
  output logic                 x_end,
  output logic                 y_end,
  output logic [X_TMP_W-1:0]   src_x,
  output logic [X_TMP_W-1:0]   dst_x,
  output logic [COORD_Y_W-1:0] src_y,
  output logic [COORD_Y_W-1:0] dst_y
);

  logic                 byte_cmd;
  logic [1:0]           max_mask;
  logic                 src_border;
  logic                 dst_border;
  logic [COORD_Y_W-1:0] nx_load;
  logic [COORD_Y_W-1:0] nx_cnt;
  logic [COORD_Y_W-1:0] ny_cnt;
  logic [X_TMP_W-1:0]   x_delta;
  logic [COORD_Y_W-1:0] y_delta;

  // High-speed byte command
  assign byte_cmd = regs.cmr[7:6] == 2'b11;

  // 512-dot modes border at bit 9, 256-dot modes at bit 8
  assign max_mask   = (mode == MODE_G5 || mode == MODE_G6) ? 2'b10 : 2'b01;
  assign src_border = (src_x[9:8] & max_mask) == max_mask;
  assign dst_border = (dst_x[9:8] & max_mask) == max_mask;

  assign y_delta = regs.diy ? '1 : COORD_Y_W'(1);

  // Byte step and dot count depend on pixels per byte
  always_comb begin
    nx_load = regs.nx;
    x_delta = X_TMP_W'(1);
    if (byte_cmd && mode == MODE_G5) begin
      nx_load = {2'b00, regs.nx[9:2]};
      x_delta = X_TMP_W'(4);
    end else if (byte_cmd && mode != MODE_G7) begin
      nx_load = {1'b0, regs.nx[9:1]};
      x_delta = X_TMP_W'(2);
    end
    if (regs.dix) begin
      x_delta = -x_delta;
    end
  end

  always_comb begin
    case (regs.cmr[7:4])
      OP_HMMV, OP_LMMV: x_end = (nx_cnt == '0) || dst_border;
      // Search runs to the border only
      OP_SRCH: x_end = src_border;
      default: x_end = 1'b1;
    endcase
  end

  // Last line, or top edge reached going up
  assign y_end = (ny_cnt == COORD_Y_W'(1)) || (regs.diy && dst_y == '0);

  always_ff @(posedge RESET or posedge CLK21M) begin
    if (CLK21M) begin
      src_x  <= '0;
      dst_x  <= '0;
      src_y  <= '0;
      dst_y  <= '0;
      nx_cnt <= '0;
      ny_cnt <= '0;
    end else if (init || next_line) begin
      // X restarts at the left of the area each line
      src_x  <= X_TMP_W'(regs.sx);
      dst_x  <= X_TMP_W'(regs.dx);
      nx_cnt <= nx_load;
      if (init) begin
        src_y  <= regs.sy;
        dst_y  <= regs.dy;
        ny_cnt <= regs.ny;
      end else begin
        src_y  <= src_y + y_delta;
        dst_y  <= dst_y + y_delta;
        ny_cnt <= ny_cnt - COORD_Y_W'(1);
      end
    end else if (step_x) begin
      src_x  <= src_x + x_delta;
      dst_x  <= dst_x + x_delta;
      nx_cnt <= nx_cnt - COORD_Y_W'(1);
    end
  end

endmodule

// ==== logic/pixel_unit.sv ====
module pixel_unit import vdp_cmd_pkg::*; (
  input  logic                   RESET,
  input  logic                   CLK21M,
  input  screen_mode_t           mode,
  input  logic [DATA_W-1:0]      vram_rd_data,
  input  logic                   ld_fill,
  input  logic                   ld_merge,
  input  logic                   addr_src,
  input  logic                   addr_dst,
  input  logic [X_TMP_W-1:0]     src_x,
  input  logic [X_TMP_W-1:0]     dst_x,
  input  logic [COORD_Y_W-1:0]   src_y,
  input  logic [COORD_Y_W-1:0]   dst_y,
  cmd_regs_if.user               regs,
  output logic [DATA_W-1:0]      vram_wr_data,
  output logic [VRAM_ADDR_W-1:0] vram_addr,
  output logic [DATA_W-1:0]      point_data,
  output logic [DATA_W-1:0]      col_mask,
  output logic                   src_match
);

  logic [1:0]             x_low;
  logic [COORD_X_W-1:0]   acc_x;
  logic [COORD_Y_W-1:0]   acc_y;
  logic [VRAM_ADDR_W-1:0] acc_addr;
  logic [DATA_W-1:0]      src_col;
  logic [DATA_W-1:0]      lop_col;
  logic [DATA_W-1:0]      merged;

  assign acc_x = addr_src ? src_x[COORD_X_W-1:0] : dst_x[COORD_X_W-1:0];
  assign acc_y = addr_src ? src_y : dst_y;

  // Byte address, Y above X over pixels per byte
  always_comb begin
    case (mode)
      MODE_G4: acc_addr = {acc_y, acc_x[7:1]};
      MODE_G5: acc_addr = {acc_y, acc_x[8:2]};
      MODE_G6: acc_addr = {acc_y[8:0], acc_x[8:1]};
      default: acc_addr = {acc_y[8:0], acc_x[7:0]};
    endcase
  end

  // Dot select, leftmost dot in the high bits
  always_comb begin
    case (mode)
      MODE_G4, MODE_G6: begin
        point_data = {4'h0, vram_rd_data[{~x_low[0], 2'b00} +: 4]};
        col_mask   = 8'h0f;
      end
      MODE_G5: begin
        point_data = {6'b000000, vram_rd_data[{~x_low, 1'b0} +: 2]};
        col_mask   = 8'h03;
      end
      default: begin
        point_data = vram_rd_data;
        col_mask   = 8'hff;
      end
    endcase
    // Byte command moves whole bytes
    if (regs.cmr[7:6] == 2'b11) begin
      col_mask = 8'hff;
    end
  end

  assign src_col = regs.clr & col_mask;

  // Logical op, transparent with colour 0 keeps the old dot
  always_comb begin
    lop_col = point_data;
    if (!regs.cmr[3] || src_col != '0) begin
      case (regs.cmr[2:0])
        LOP_IMP: lop_col = src_col;
        LOP_AND: lop_col = src_col & point_data;
        LOP_OR:  lop_col = src_col | point_data;
        LOP_EOR: lop_col = src_col ^ point_data;
        LOP_NOT: lop_col = ~src_col;
        default: lop_col = point_data;
      endcase
    end
  end

  // Result back into the byte, neighbours untouched
  always_comb begin
    merged = vram_rd_data;
    case (mode)
      MODE_G4, MODE_G6: merged[{~x_low[0], 2'b00} +: 4] = lop_col[3:0];
      MODE_G5:          merged[{~x_low, 1'b0} +: 2] = lop_col[1:0];
      default:          merged = lop_col;
    endcase
  end

  // Compared against EQ by the sequencer
  assign src_match = point_data != src_col;

  always_ff @(posedge RESET or posedge CLK21M) begin
    if (CLK21M) begin
      x_low        <= 2'b00;
      vram_addr    <= '0;
      vram_wr_data <= '0;
    end else begin
      if (addr_src || addr_dst) begin
        x_low     <= acc_x[1:0];
        vram_addr <= acc_addr;
      end
      if (ld_fill) begin
        vram_wr_data <= src_col;
      end else if (ld_merge) begin
        vram_wr_data <= merged;
      end
    end
  end

endmodule

// ==== logic/cmd_sequencer.sv ====
module cmd_sequencer import vdp_cmd_pkg::*; (
  input  logic       RESET,
  input  logic       CLK21M,
  input  logic       start_pend,
  input  logic       reg_busy,
  input  logic       x_end,
  input  logic       y_end,
  input  logic       src_match,
  input  logic       vram_wr_ack,
  input  logic       vram_rd_ack,
  cmd_regs_if.user   regs,
  output logic       vram_wr_req,
  output logic       vram_rd_req,
  output logic       start_take,
  output logic       load_point,
  output logic       init,
  output logic       step_x,
  output logic       next_line,
  output logic       ld_fill,
  output logic       ld_merge,
  output logic       addr_src,
  output logic       addr_dst,
  output logic       ce,
  output logic       bd,
  output cmd_state_t state
);

  cmd_state_t state_nxt;
  logic [3:0] op;
  logic       rd_done;
  logic       wr_done;
  logic       first_pass;
  logic       issue_rd;
  logic       issue_wr;
  logic       found;

  assign op      = regs.cmr[7:4];
  assign rd_done = vram_rd_req == vram_rd_ack;
  assign wr_done = vram_wr_req == vram_wr_ack;

  always_comb begin
    state_nxt  = state;
    start_take = 1'b0;
    load_point = 1'b0;
    init       = 1'b0;
    step_x     = 1'b0;
    next_line  = 1'b0;
    ld_fill    = 1'b0;
    ld_merge   = 1'b0;
    addr_src   = 1'b0;
    addr_dst   = 1'b0;
    issue_rd   = 1'b0;
    issue_wr   = 1'b0;
    found      = 1'b0;
    // Register write wins, FSM holds
    if (!reg_busy) begin
      if (start_pend && state != ST_IDLE) begin
        // New R46 aborts the running command
        state_nxt = ST_IDLE;
      end else begin
        case (state)
          ST_IDLE: begin
            if (start_pend) begin
              start_take = 1'b1;
              init       = 1'b1;
              state_nxt  = ST_CHK_LOOP;
            end
          end
          ST_CHK_LOOP: begin
            // End of row, move to the next line
            next_line = !first_pass && x_end;
            if (!first_pass && x_end && y_end) begin
              state_nxt = ST_END;
            end else begin
              case (op)
                OP_HMMV:           state_nxt = ST_WR;
                OP_LMMV, OP_PSET:  state_nxt = ST_PRE_RD;
                OP_POINT, OP_SRCH: state_nxt = ST_RD;
                default:           state_nxt = ST_END;
              endcase
            end
          end
          ST_RD: begin
            addr_src  = 1'b1;
            issue_rd  = 1'b1;
            state_nxt = ST_WAIT_RD;
          end
          ST_WAIT_RD: begin
            if (rd_done) begin
              if (op == OP_POINT) begin
                load_point = 1'b1;
                state_nxt  = ST_END;
              end else if (src_match == regs.eq) begin
                found     = 1'b1;
                state_nxt = ST_END;
              end else begin
                step_x    = 1'b1;
                state_nxt = ST_SRCH_CHK;
              end
            end
          end
          ST_PRE_RD: begin
            addr_dst  = 1'b1;
            issue_rd  = 1'b1;
            state_nxt = ST_WAIT_PRE_RD;
          end
          ST_WAIT_PRE_RD: begin
            if (rd_done) begin
              ld_merge  = 1'b1;
              state_nxt = ST_WR;
            end
          end
          ST_WR: begin
            // HMMV writes the plain colour, others the merged byte
            ld_fill   = op == OP_HMMV;
            addr_dst  = 1'b1;
            issue_wr  = 1'b1;
            state_nxt = ST_WAIT_WR;
          end
          ST_WAIT_WR: begin
            if (wr_done) begin
              if (op == OP_PSET) begin
                state_nxt = ST_END;
              end else begin
                step_x    = 1'b1;
                state_nxt = ST_CHK_LOOP;
              end
            end
          end
          ST_SRCH_CHK: state_nxt = x_end ? ST_END : ST_RD;
          default:     state_nxt = ST_IDLE;
        endcase
      end
    end
  end

  always_ff @(posedge RESET or posedge CLK21M) begin
    if (CLK21M) begin
      state       <= ST_IDLE;
      first_pass  <= 1'b0;
      ce          <= 1'b0;
      bd          <= 1'b0;
      vram_wr_req <= 1'b0;
      vram_rd_req <= 1'b0;
    end else begin
      state <= state_nxt;
      // Loop-end test skipped on the first pass
      if (start_take) begin
        first_pass <= 1'b1;
        ce         <= 1'b1;
        bd         <= 1'b0;
      end else if (state == ST_CHK_LOOP) begin
        first_pass <= 1'b0;
      end
      if (state == ST_END && state_nxt == ST_IDLE) begin
        ce <= 1'b0;
      end
      if (found) begin
        bd <= 1'b1;
      end
      // Toggle away from the ack to open an access
      if (issue_rd) begin
        vram_rd_req <= ~vram_rd_ack;
      end
      if (issue_wr) begin
        vram_wr_req <= ~vram_wr_ack;
      end
    end
  end

endmodule

// ==== logic/vdp_command.sv ====
module vdp_command import vdp_cmd_pkg::*; (
  input  logic                   RESET,
  input  logic                   CLK21M,
  input  logic                   graphic4,
  input  logic                   graphic5,
  input  logic                   graphic6,
  input  logic                   graphic7,
  input  logic                   reg_wr_req,
  input  logic [3:0]             reg_num,
  input  logic [DATA_W-1:0]      reg_data,
  output logic                   reg_wr_ack,
  output logic                   vram_wr_req,
  input  logic                   vram_wr_ack,
  output logic                   vram_rd_req,
  input  logic                   vram_rd_ack,
  output logic [VRAM_ADDR_W-1:0] vram_addr,
  output logic [DATA_W-1:0]      vram_wr_data,
  input  logic [DATA_W-1:0]      vram_rd_data,
  output logic [DATA_W-1:0]      clr,
  output logic                   ce,
  output logic                   bd,
  output logic [3:0]             cur_cmd
);

  screen_mode_t         mode;
  logic                 mode_valid;
  logic                 reg_busy;
  logic                 start_pend;
  logic                 start_take;
  logic                 load_point;
  logic                 init;
  logic                 step_x;
  logic                 next_line;
  logic                 ld_fill;
  logic                 ld_merge;
  logic                 addr_src;
  logic                 addr_dst;
  logic                 x_end;
  logic                 y_end;
  logic                 src_match;
  logic [X_TMP_W-1:0]   src_x;
  logic [X_TMP_W-1:0]   dst_x;
  logic [COORD_Y_W-1:0] src_y;
  logic [COORD_Y_W-1:0] dst_y;
  logic [DATA_W-1:0]    point_data;
  logic [DATA_W-1:0]    col_mask;
  cmd_state_t           cmd_state;

  cmd_regs_if u_regs ();

  // One mode bit expected, lowest wins
  always_comb begin
    if (graphic4) begin
      mode = MODE_G4;
    end else if (graphic5) begin
      mode = MODE_G5;
    end else if (graphic6) begin
      mode = MODE_G6;
    end else begin
      mode = MODE_G7;
    end
  end

  assign mode_valid = graphic4 | graphic5 | graphic6 | graphic7;
  assign reg_busy   = reg_wr_req != reg_wr_ack;
  assign clr        = u_regs.clr;
  assign cur_cmd    = u_regs.cmr[7:4];

  cmd_reg_bank u_cmd_reg_bank (
    .RESET, .CLK21M, .reg_wr_req, .reg_num, .reg_data, .mode_valid,
    .start_take, .load_point, .point_data, .col_mask, .ce,
    .reg_wr_ack, .start_pend, .regs(u_regs.bank)
  );

  area_counter u_area_counter (
    .RESET, .CLK21M, .mode, .init, .step_x, .next_line, .regs(u_regs.user),
    .x_end, .y_end, .src_x, .dst_x, .src_y, .dst_y
  );

  pixel_unit u_pixel_unit (
    .RESET, .CLK21M, .mode, .vram_rd_data, .ld_fill, .ld_merge, .addr_src, .addr_dst,
    .src_x, .dst_x, .src_y, .dst_y, .regs(u_regs.user),
    .vram_wr_data, .vram_addr, .point_data, .col_mask, .src_match
  );

  // State exported for the bound checks
  cmd_sequencer u_cmd_sequencer (
    .RESET, .CLK21M, .start_pend, .reg_busy, .x_end, .y_end, .src_match,
    .vram_wr_ack, .vram_rd_ack, .regs(u_regs.user),
    .vram_wr_req, .vram_rd_req, .start_take, .load_point, .init, .step_x, .next_line,
    .ld_fill, .ld_merge, .addr_src, .addr_dst, .ce, .bd, .state(cmd_state)
  );

endmodule

// ==== tests/tb_clock_gen.sv ====
module tb_clock_gen (
  output logic RESET,
  output logic CLK21M
);

  timeunit 1ns;
  timeprecision 1ps;

  localparam time HALF_PERIOD = 10ns;

  // Design naming keeps RESET as the clock and CLK21M as the reset
  initial begin
    RESET  = 1'b0;
    CLK21M = 1'b1;
    forever #(HALF_PERIOD) RESET = ~RESET;
  end

  // Reset held for three clock cycles
  initial begin
    repeat (3) @(posedge RESET);
    CLK21M <= 1'b0;
  end

endmodule

// ==== tests/vdp_command_sva.sv ====
module vdp_command_sva import vdp_cmd_pkg::*; (
  input logic                   RESET,
  input logic                   CLK21M,
  input logic                   graphic4,
  input logic                   graphic7,
  input logic                   reg_wr_req,
  input logic                   reg_wr_ack,
  input logic                   vram_wr_req,
  input logic                   vram_rd_req,
  input logic                   vram_rd_ack,
  input logic [VRAM_ADDR_W-1:0] vram_addr,
  input logic [DATA_W-1:0]      vram_wr_data,
  input logic [DATA_W-1:0]      vram_rd_data,
  input logic [DATA_W-1:0]      clr,
  input logic                   ce,
  input logic                   bd,
  input logic [3:0]             cur_cmd,
  input cmd_state_t             cmd_state,
  input logic [DATA_W-1:0]      cmr,
  input logic [COORD_X_W-1:0]   dx,
  input logic [COORD_Y_W-1:0]   dy,
  input logic [COORD_Y_W-1:0]   nx,
  input logic [COORD_Y_W-1:0]   ny,
  input logic                   dix,
  input logic                   diy,
  input logic [X_TMP_W-1:0]     dst_x
);

  timeunit 1ns;
  timeprecision 1ps;

  int unsigned       fail_cnt = 0;
  logic [DATA_W-1:0] last_rd;
  logic              wr_req_q;
  logic              rd_req_q;
  logic [3:0]        col;
  logic [DATA_W-1:0] or_byte;
  logic              wr_issue;
  logic              hmmv_g7;
  logic              in_rect;

  // Byte from the last completed read
  always_ff @(posedge RESET) begin
    if (vram_rd_req == vram_rd_ack) begin
      last_rd <= vram_rd_data;
    end
  end

  // Request levels one cycle back
  always_ff @(posedge RESET) begin
    wr_req_q <= vram_wr_req;
    rd_req_q <= vram_rd_req;
  end

  assign wr_issue = vram_wr_req != wr_req_q;
  assign hmmv_g7  = cur_cmd == OP_HMMV && graphic7 && !dix && !diy;
  assign in_rect  = int'(vram_addr[7:0]) >= int'(dx[7:0])
                 && int'(vram_addr[7:0]) < int'(dx[7:0]) + int'(nx)
                 && int'(vram_addr[16:8]) >= int'(dy[8:0])
                 && int'(vram_addr[16:8]) < int'(dy[8:0]) + int'(ny);

  // Leftmost dot in the high nibble
  assign col     = clr[3:0];
  assign or_byte = dst_x[0] ? {last_rd[7:4], last_rd[3:0] | col}
                            : {last_rd[7:4] | col, last_rd[3:0]};

  // Idle outputs right after reset
  a_reset_idle: assert property (@(posedge RESET) $fell(CLK21M) |->
      !ce && !bd && !vram_wr_req && !vram_rd_req && cmd_state == ST_IDLE && cur_cmd == 4'h0)
    else begin
      $error("[ERROR] %0t ce/bd/vram_req expected 0 actual %b%b%b%b", $time,
             $sampled(ce), $sampled(bd), $sampled(vram_wr_req), $sampled(vram_rd_req));
      fail_cnt++;
    end

  a_reg_ack: assert property (@(posedge RESET) disable iff (CLK21M)
      reg_wr_req != reg_wr_ack |=> reg_wr_req == reg_wr_ack)
    else begin
      $error("[ERROR] %0t reg_wr_ack expected %b actual %b", $time,
             $sampled(reg_wr_req), $sampled(reg_wr_ack));
      fail_cnt++;
    end

  a_hmmv_data: assert property (@(posedge RESET) disable iff (CLK21M)
      wr_issue && hmmv_g7 |-> vram_wr_data == clr)
    else begin
      $error("[ERROR] %0t vram_wr_data expected %h actual %h", $time,
             $sampled(clr), $sampled(vram_wr_data));
      fail_cnt++;
    end

  a_hmmv_rect: assert property (@(posedge RESET) disable iff (CLK21M)
      wr_issue && hmmv_g7 |-> in_rect)
    else begin
      $error("[ERROR] %0t vram_addr expected inside rectangle actual %h", $time,
             $sampled(vram_addr));
      fail_cnt++;
    end

  // HMMV never reads
  a_hmmv_no_rd: assert property (@(posedge RESET) disable iff (CLK21M)
      ce && cur_cmd == OP_HMMV |-> vram_rd_req == rd_req_q)
    else begin
      $error("[ERROR] %0t vram_rd_req expected %b actual %b", $time,
             $sampled(rd_req_q), $sampled(vram_rd_req));
      fail_cnt++;
    end

  a_lmmv_or: assert property (@(posedge RESET) disable iff (CLK21M)
      wr_issue && cur_cmd == OP_LMMV && graphic4 && cmr[3:0] == {1'b0, LOP_OR}
      |-> vram_wr_data == or_byte)
    else begin
      $error("[ERROR] %0t vram_wr_data expected %h actual %h", $time,
             $sampled(or_byte), $sampled(vram_wr_data));
      fail_cnt++;
    end

  // Transparent IMP with colour 0 rewrites the old byte
  a_pset_timp: assert property (@(posedge RESET) disable iff (CLK21M)
      wr_issue && cur_cmd == OP_PSET && cmr[3:0] == {1'b1, LOP_IMP} && clr == 8'h00
      |-> vram_wr_data == last_rd)
    else begin
      $error("[ERROR] %0t vram_wr_data expected %h actual %h", $time,
             $sampled(last_rd), $sampled(vram_wr_data));
      fail_cnt++;
    end

endmodule

bind vdp_command vdp_command_sva u_vdp_command_sva (
  .RESET, .CLK21M, .graphic4, .graphic7, .reg_wr_req, .reg_wr_ack,
  .vram_wr_req, .vram_rd_req, .vram_rd_ack, .vram_addr, .vram_wr_data, .vram_rd_data,
  .clr, .ce, .bd, .cur_cmd, .cmd_state,
  .cmr(u_regs.cmr), .dx(u_regs.dx), .dy(u_regs.dy), .nx(u_regs.nx), .ny(u_regs.ny),
  .dix(u_regs.dix), .diy(u_regs.diy), .dst_x
);

// ==== tests/vdp_command_tb.sv ====
module vdp_command_tb import vdp_cmd_pkg::*;;

  timeunit 1ns;
  timeprecision 1ps;

  localparam int  MEM_SIZE   = 131072;
  localparam time CLK_PERIOD = 20ns;
  // Worst case of fills, pre-reads, two searches and the register writes
  localparam int  MAX_ACCESS = 12 + 20 + 2 + 1 + 2 * 56 + 7 * 15;
  localparam time WATCHDOG   = (MAX_ACCESS * 6 + 500) * CLK_PERIOD;

  logic                   RESET;
  logic                   CLK21M;
  logic                   graphic4;
  logic                   graphic5;
  logic                   graphic6;
  logic                   graphic7;
  logic                   reg_wr_req;
  logic [3:0]             reg_num;
  logic [DATA_W-1:0]      reg_data;
  logic                   reg_wr_ack;
  logic                   vram_wr_req;
  logic                   vram_wr_ack;
  logic                   vram_rd_req;
  logic                   vram_rd_ack;
  logic [VRAM_ADDR_W-1:0] vram_addr;
  logic [DATA_W-1:0]      vram_wr_data;
  logic [DATA_W-1:0]      vram_rd_data;
  logic [DATA_W-1:0]      clr;
  logic                   ce;
  logic                   bd;
  logic [3:0]             cur_cmd;

  logic [DATA_W-1:0] mem [MEM_SIZE];
  int                seed = 32'hf12f_9d10;
  int                rd_cnt;
  int                wr_cnt;
  int                err_cnt;
  int                test_cnt;

  tb_clock_gen u_tb_clock_gen (.RESET, .CLK21M);

  vdp_command u_vdp_command (.*);

  // VRAM model answering each toggle after 1 to 4 cycles
  always @(posedge RESET) begin
    if (CLK21M) begin
      rd_cnt = 0;
      wr_cnt = 0;
    end else begin
      if (vram_rd_req != vram_rd_ack) begin
        if (rd_cnt == 0) begin
          rd_cnt = 1 + ($random(seed) & 3);
        end
        rd_cnt = rd_cnt - 1;
        if (rd_cnt == 0) begin
          vram_rd_data <= mem[vram_addr];
          vram_rd_ack  <= vram_rd_req;
        end
      end
      if (vram_wr_req != vram_wr_ack) begin
        if (wr_cnt == 0) begin
          wr_cnt = 1 + ($random(seed) & 3);
        end
        wr_cnt = wr_cnt - 1;
        if (wr_cnt == 0) begin
          mem[vram_addr] = vram_wr_data;
          vram_wr_ack <= vram_wr_req;
        end
      end
    end
  end

  function automatic int total_errors();
    return err_cnt + int'(u_vdp_command.u_vdp_command_sva.fail_cnt);
  endfunction

  task automatic write_reg(input logic [3:0] num, input logic [7:0] data);
    @(posedge RESET);
    reg_num    <= num;
    reg_data   <= data;
    reg_wr_req <= ~reg_wr_req;
    do begin
      @(posedge RESET);
    end while (reg_wr_ack != reg_wr_req);
  endtask

  task automatic select_mode(input logic [3:0] bits);
    @(posedge RESET);
    {graphic7, graphic6, graphic5, graphic4} <= bits;
  endtask

  // Coordinates, sizes, colour and argument with all directions positive
  task automatic load_area(input int sx, input int sy, input int dx, input int dy,
                           input int nx, input int ny, input logic [7:0] col);
    write_reg(REG_SX_L, sx[7:0]);
    write_reg(REG_SX_H, {7'd0, sx[8]});
    write_reg(REG_SY_L, sy[7:0]);
    write_reg(REG_SY_H, {6'd0, sy[9:8]});
    write_reg(REG_DX_L, dx[7:0]);
    write_reg(REG_DX_H, {7'd0, dx[8]});
    write_reg(REG_DY_L, dy[7:0]);
    write_reg(REG_DY_H, {6'd0, dy[9:8]});
    write_reg(REG_NX_L, nx[7:0]);
    write_reg(REG_NX_H, {6'd0, nx[9:8]});
    write_reg(REG_NY_L, ny[7:0]);
    write_reg(REG_NY_H, {6'd0, ny[9:8]});
    write_reg(REG_CLR, col);
    write_reg(REG_ARG, 8'h00);
  endtask

  // Start through R46 and wait for ce to rise and fall again
  task automatic run_cmd(input string name, input logic [7:0] cmd);
    write_reg(REG_CMD, cmd);
    do begin
      @(posedge RESET);
    end while (!ce);
    // Running opcode is the upper nibble of R46
    a_cur_cmd: assert (cur_cmd == cmd[7:4])
      else begin
        $error("[ERROR] %0t cur_cmd expected %h actual %h", $time, cmd[7:4], cur_cmd);
        err_cnt++;
      end
    do begin
      @(posedge RESET);
    end while (ce);
    test_cnt++;
    $display("%0t test %s finished, errors so far %0d", $time, name, total_errors());
  endtask

  // Any dot equal to the colour from sx up to the G7 border
  function automatic logic search_hit(input int sx, input int sy, input logic [7:0] col);
    logic hit;
    hit = 1'b0;
    for (int x = sx; x < 256; x++) begin
      if (mem[sy * 256 + x] == col) begin
        hit = 1'b1;
      end
    end
    return hit;
  endfunction

  initial begin
    #(WATCHDOG);
    $display("Timeout: the command tests did not complete in time");
    $display("Errors found");
    $finish;
  end

  initial begin
    logic [7:0] byte_v;
    logic [7:0] dot;
    logic [7:0] miss_col;
    logic       exp_bd;
    graphic4     = 1'b0;
    graphic5     = 1'b0;
    graphic6     = 1'b0;
    graphic7     = 1'b0;
    reg_wr_req   = 1'b0;
    reg_num      = 4'h0;
    reg_data     = 8'h00;
    vram_wr_ack  = 1'b0;
    vram_rd_ack  = 1'b0;
    vram_rd_data = 8'h00;
    err_cnt      = 0;
    test_cnt     = 0;
    for (int i = 0; i < MEM_SIZE; i++) begin
      mem[i] = 8'($random(seed));
    end
    wait (!CLK21M);

    // Reset state and register handshake
    write_reg(REG_SX_L, 8'h12);
    write_reg(REG_ARG, 8'h00);
    test_cnt++;
    $display("%0t test reset finished, errors so far %0d", $time, total_errors());

    select_mode(4'b1000);
    load_area(0, 0, 10, 5, 4, 3, 8'h5a);
    run_cmd("hmmv_g7", {OP_HMMV, 4'h0});

    select_mode(4'b0001);
    load_area(0, 0, 7, 20, 5, 2, 8'h09);
    run_cmd("lmmv_or_g4", {OP_LMMV, 1'b0, LOP_OR});

    load_area(0, 0, 33, 40, 1, 1, 8'h00);
    run_cmd("pset_timp_g4", {OP_PSET, 1'b1, LOP_IMP});

    // Dot k of a G5 byte sits at bits 7-2k and 6-2k
    select_mode(4'b0010);
    load_area(13, 50, 0, 0, 1, 1, 8'h00);
    byte_v = mem[50 * 128 + 13 / 4];
    dot    = (byte_v >> (6 - 2 * (13 % 4))) & 8'h03;
    run_cmd("point_g5", {OP_POINT, 4'h0});
    a_point_clr: assert (clr == dot)
      else begin
        $error("[ERROR] %0t clr expected %h actual %h", $time, dot, clr);
        err_cnt++;
      end

    // Search hit with the colour taken from the searched row
    select_mode(4'b1000);
    load_area(200, 60, 0, 0, 1, 1, mem[60 * 256 + 230]);
    exp_bd = search_hit(200, 60, mem[60 * 256 + 230]);
    run_cmd("srch_hit_g7", {OP_SRCH, 4'h0});
    a_srch_hit: assert (bd == exp_bd)
      else begin
        $error("[ERROR] %0t bd expected %b actual %b", $time, exp_bd, bd);
        err_cnt++;
      end

    // Search miss on the first colour absent from the row
    miss_col = 8'h00;
    while (search_hit(200, 61, miss_col) && miss_col != 8'hff) begin
      miss_col++;
    end
    load_area(200, 61, 0, 0, 1, 1, miss_col);
    exp_bd = search_hit(200, 61, miss_col);
    run_cmd("srch_miss_g7", {OP_SRCH, 4'h0});
    a_srch_miss: assert (bd == exp_bd)
      else begin
        $error("[ERROR] %0t bd expected %b actual %b", $time, exp_bd, bd);
        err_cnt++;
      end

    repeat (4) @(posedge RESET);
    $display("Tests run %0d, errors %0d", test_cnt, total_errors());
    if (total_errors() == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

// ==== verilog.f ====
common/vdp_cmd_pkg.sv
common/cmd_regs_if.sv
logic/cmd_reg_bank.sv
logic/area_counter.sv
logic/pixel_unit.sv
logic/cmd_sequencer.sv
logic/vdp_command.sv
tests/tb_clock_gen.sv
tests/vdp_command_sva.sv
tests/vdp_command_tb.sv

// ==== Makefile ====
TOOL     = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = vdp_command_tb
FILELIST = verilog.f
OBJDIR   = obj_dir
LOG      = sim.log

.PHONY: simulate clean

simulate:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)
	./$(OBJDIR)/V$(TOP) | tee $(LOG)
	grep -q "^No errors$$" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)
